/* common/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

  // Default datapath width, overridden through DATA_WIDTH
  localparam int XLEN_DEFAULT = 32;

  // Register number width, fixed by the ISA
  localparam int REG_ADDR_W = 5;

  // ALU operations for RV32I register and immediate forms
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_sll    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_slt    = 4'd8,
    alu_sltu   = 4'd9,
    alu_pass_b = 4'd10  // LUI, right operand straight through
  } alu_op_t;

  // Branch conditions, JAL is unconditional
  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_beq  = 3'd1,
    br_bne  = 3'd2,
    br_blt  = 3'd3,
    br_bge  = 3'd4,
    br_bltu = 3'd5,
    br_bgeu = 3'd6,
    br_jal  = 3'd7
  } branch_op_t;

  // Where an operand comes from
  typedef enum logic [1:0] {
    fwd_none   = 2'd0,  // Register file
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_t;

endpackage

`default_nettype wire

/* execute/forwarding_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module forwarding_unit #(
  parameter int DATA_WIDTH = 32
) (
  input  logic [riscv_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] rs2,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] ex_mem_rd,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] mem_wb_rd,
  input  logic                             ex_mem_reg_write,
  input  logic                             mem_wb_reg_write,
  input  logic [DATA_WIDTH-1:0]            data1,
  input  logic [DATA_WIDTH-1:0]            data2,
  input  logic [DATA_WIDTH-1:0]            immediate,
  input  logic [DATA_WIDTH-1:0]            ex_mem_result,
  input  logic [DATA_WIDTH-1:0]            mem_wb_result,
  input  logic                             alu_src,
  output logic [DATA_WIDTH-1:0]            rs1_value,
  output logic [DATA_WIDTH-1:0]            rs2_value,
  output logic [DATA_WIDTH-1:0]            left_operand,
  output logic [DATA_WIDTH-1:0]            right_operand
);

  import riscv_pkg::*;

  fwd_sel_t rs1_sel;
  fwd_sel_t rs2_sel;

  // Newest producer wins, x0 is never forwarded
  function automatic fwd_sel_t pick_source(input logic [REG_ADDR_W-1:0] src);
    if (ex_mem_reg_write && (ex_mem_rd != '0) && (ex_mem_rd == src))
      return fwd_ex_mem;
    else if (mem_wb_reg_write && (mem_wb_rd != '0) && (mem_wb_rd == src))
      return fwd_mem_wb;
    else
      return fwd_none;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] steer(input fwd_sel_t sel,
                                                  input logic [DATA_WIDTH-1:0] rf_value);
    case (sel)
      fwd_ex_mem: return ex_mem_result;
      fwd_mem_wb: return mem_wb_result;
      default:    return rf_value;
    endcase
  endfunction

  always_comb begin
    rs1_sel = pick_source(rs1);
    rs2_sel = pick_source(rs2);

    rs1_value = steer(rs1_sel, data1);
    rs2_value = steer(rs2_sel, data2);  // Also the store data

    left_operand  = rs1_value;
    right_operand = alu_src ? immediate : rs2_value;
  end

endmodule

`default_nettype wire

/* execute/alu.sv */
`timescale 1ns/100ps
`default_nettype none

module alu #(
  parameter int DATA_WIDTH = 32
) (
  input  riscv_pkg::alu_op_t     alu_op,
  input  logic [DATA_WIDTH-1:0]  left_operand,
  input  logic [DATA_WIDTH-1:0]  right_operand,
  output logic [DATA_WIDTH-1:0]  result
);

  import riscv_pkg::*;

  // 5 bits for RV32, 6 for RV64
  localparam int SHAMT_W = $clog2(DATA_WIDTH);

  logic [SHAMT_W-1:0] shamt;
  logic               less_signed;
  logic               less_unsigned;

  assign shamt         = right_operand[SHAMT_W-1:0];
  assign less_signed   = $signed(left_operand) < $signed(right_operand);
  assign less_unsigned = left_operand < right_operand;

  always_comb begin
    case (alu_op)
      alu_add:    result = left_operand + right_operand;  // Wraps
      alu_sub:    result = left_operand - right_operand;
      alu_and:    result = left_operand & right_operand;
      alu_or:     result = left_operand | right_operand;
      alu_xor:    result = left_operand ^ right_operand;
      alu_sll:    result = left_operand << shamt;
      alu_srl:    result = left_operand >> shamt;
      alu_sra:    result = $signed(left_operand) >>> shamt;
      alu_slt: begin
        result    = '0;
        result[0] = less_signed;
      end
      alu_sltu: begin
        result    = '0;
        result[0] = less_unsigned;
      end
      alu_pass_b: result = right_operand;
      default:    result = '0;  // Unused encodings
    endcase
  end

endmodule

`default_nettype wire

/* execute/branch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_unit #(
  parameter int DATA_WIDTH = 32
) (
  input  riscv_pkg::branch_op_t  branch_op,
  input  logic [DATA_WIDTH-1:0]  rs1_value,
  input  logic [DATA_WIDTH-1:0]  rs2_value,
  input  logic [DATA_WIDTH-1:0]  pc,
  input  logic [DATA_WIDTH-1:0]  immediate,
  output logic                   taken,
  output logic [DATA_WIDTH-1:0]  target,
  output logic [DATA_WIDTH-1:0]  link
);

  import riscv_pkg::*;

  logic equal;
  logic less_signed;
  logic less_unsigned;

  // Comparator of its own, runs alongside the ALU
  assign equal         = rs1_value == rs2_value;
  assign less_signed   = $signed(rs1_value) < $signed(rs2_value);
  assign less_unsigned = rs1_value < rs2_value;

  assign target = pc + immediate;
  assign link   = pc + DATA_WIDTH'(4);  // Return address for JAL

  always_comb begin
    case (branch_op)
      br_beq:  taken = equal;
      br_bne:  taken = !equal;
      br_blt:  taken = less_signed;
      br_bge:  taken = !less_signed;
      br_bltu: taken = less_unsigned;
      br_bgeu: taken = !less_unsigned;
      br_jal:  taken = 1'b1;
      default: taken = 1'b0;  // br_none
    endcase
  end

endmodule

`default_nettype wire

/* execute/ex_mem_register.sv */
`timescale 1ns/100ps
`default_nettype none

module ex_mem_register #(
  parameter int DATA_WIDTH = 32
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             valid_in,
  input  riscv_pkg::branch_op_t            branch_op,
  input  logic [DATA_WIDTH-1:0]            alu_result,
  input  logic [DATA_WIDTH-1:0]            link,
  input  logic [DATA_WIDTH-1:0]            store_data,
  input  logic [DATA_WIDTH-1:0]            target,
  input  logic                             taken,
  input  logic                             mem_read,
  input  logic                             mem_write,
  input  logic                             reg_write,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] rd_in,
  output logic                             valid_out,
  output logic [DATA_WIDTH-1:0]            alu_data,
  output logic [DATA_WIDTH-1:0]            memory_data,
  output logic [DATA_WIDTH-1:0]            branch_target,
  output logic [riscv_pkg::REG_ADDR_W-1:0] rd_out,
  output logic                             reg_write_out,
  output logic                             mem_read_out,
  output logic                             mem_write_out,
  output logic                             branch_taken
);

  import riscv_pkg::*;

  logic [DATA_WIDTH-1:0] merged_result;

  // JAL writes the return address, everything else the ALU value
  assign merged_result = (branch_op == br_jal) ? link : alu_result;

  // Control bits, dropped to 0 on bubbles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out     <= 1'b0;
      reg_write_out <= 1'b0;
      mem_read_out  <= 1'b0;
      mem_write_out <= 1'b0;
      branch_taken  <= 1'b0;
    end else begin
      valid_out     <= valid_in;
      reg_write_out <= valid_in & reg_write;
      mem_read_out  <= valid_in & mem_read;
      mem_write_out <= valid_in & mem_write;
      branch_taken  <= valid_in & taken;
    end
  end

  // Payload holds until the next issue
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_data      <= '0;
      memory_data   <= '0;
      branch_target <= '0;
      rd_out        <= '0;
    end else if (valid_in) begin
      alu_data      <= merged_result;
      memory_data   <= store_data;
      branch_target <= target;
      rd_out        <= rd_in;
    end
  end

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
  parameter int DATA_WIDTH = riscv_pkg::XLEN_DEFAULT
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             valid_in,
  input  logic [DATA_WIDTH-1:0]            pc,
  input  logic [DATA_WIDTH-1:0]            data1,
  input  logic [DATA_WIDTH-1:0]            data2,
  input  logic [DATA_WIDTH-1:0]            immediate,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] rs1,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] rs2,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] rd_in,
  input  riscv_pkg::alu_op_t               alu_op,
  input  logic                             alu_src,
  input  riscv_pkg::branch_op_t            branch_op,
  input  logic                             mem_read,
  input  logic                             mem_write,
  input  logic                             reg_write,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] ex_mem_rd,
  input  logic                             ex_mem_reg_write,
  input  logic [DATA_WIDTH-1:0]            ex_mem_result,
  input  logic [riscv_pkg::REG_ADDR_W-1:0] mem_wb_rd,
  input  logic                             mem_wb_reg_write,
  input  logic [DATA_WIDTH-1:0]            mem_wb_result,
  output logic                             valid_out,
  output logic [DATA_WIDTH-1:0]            alu_data,
  output logic [DATA_WIDTH-1:0]            memory_data,
  output logic [DATA_WIDTH-1:0]            branch_target,
  output logic [riscv_pkg::REG_ADDR_W-1:0] rd_out,
  output logic                             reg_write_out,
  output logic                             mem_read_out,
  output logic                             mem_write_out,
  output logic                             branch_taken
);

  logic [DATA_WIDTH-1:0] rs1_value;
  logic [DATA_WIDTH-1:0] rs2_value;  // Forwarded, also the store data
  logic [DATA_WIDTH-1:0] left_operand;
  logic [DATA_WIDTH-1:0] right_operand;
  logic [DATA_WIDTH-1:0] alu_result;
  logic [DATA_WIDTH-1:0] target;
  logic [DATA_WIDTH-1:0] link;
  logic                  taken;

  forwarding_unit #(.DATA_WIDTH(DATA_WIDTH)) u_forwarding_unit (
    .rs1(rs1), .rs2(rs2), .ex_mem_rd(ex_mem_rd), .mem_wb_rd(mem_wb_rd),
    .ex_mem_reg_write(ex_mem_reg_write), .mem_wb_reg_write(mem_wb_reg_write),
    .data1(data1), .data2(data2), .immediate(immediate),
    .ex_mem_result(ex_mem_result), .mem_wb_result(mem_wb_result), .alu_src(alu_src),
    .rs1_value(rs1_value), .rs2_value(rs2_value),
    .left_operand(left_operand), .right_operand(right_operand)
  );

  alu #(.DATA_WIDTH(DATA_WIDTH)) u_alu (
    .alu_op(alu_op), .left_operand(left_operand), .right_operand(right_operand),
    .result(alu_result)
  );

  // Sits beside the ALU on the forwarded register values
  branch_unit #(.DATA_WIDTH(DATA_WIDTH)) u_branch_unit (
    .branch_op(branch_op), .rs1_value(rs1_value), .rs2_value(rs2_value),
    .pc(pc), .immediate(immediate), .taken(taken), .target(target), .link(link)
  );

  ex_mem_register #(.DATA_WIDTH(DATA_WIDTH)) u_ex_mem_register (
    .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .branch_op(branch_op),
    .alu_result(alu_result), .link(link), .store_data(rs2_value), .target(target),
    .taken(taken), .mem_read(mem_read), .mem_write(mem_write), .reg_write(reg_write),
    .rd_in(rd_in), .valid_out(valid_out), .alu_data(alu_data),
    .memory_data(memory_data), .branch_target(branch_target), .rd_out(rd_out),
    .reg_write_out(reg_write_out), .mem_read_out(mem_read_out),
    .mem_write_out(mem_write_out), .branch_taken(branch_taken)
  );

endmodule

`default_nettype wire

/* testbench/execute_stage_props.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage_props #(
  parameter int DATA_WIDTH = 32
) (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             valid_in,
  input riscv_pkg::branch_op_t            branch_op,
  input logic                             valid_out,
  input logic                             reg_write_out,
  input logic                             mem_read_out,
  input logic                             mem_write_out,
  input logic                             branch_taken,
  input logic [DATA_WIDTH-1:0]            alu_data,
  input logic [DATA_WIDTH-1:0]            memory_data,
  input logic [DATA_WIDTH-1:0]            branch_target,
  input logic [riscv_pkg::REG_ADDR_W-1:0] rd_out
);

  import riscv_pkg::*;

  logic control_any;

  assign control_any = reg_write_out | mem_read_out | mem_write_out | branch_taken;

  // One cycle of latency, issue or bubble
  a_issue_follows: assert property (@(posedge clk) disable iff (!rst_n)
    valid_in |=> valid_out) else $error("valid_out missed an issue");

  a_bubble_follows: assert property (@(posedge clk) disable iff (!rst_n)
    !valid_in |=> !valid_out) else $error("valid_out high after a bubble");

  a_quiet_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    !valid_out |-> !control_any) else $error("control output high without valid_out");

  a_taken_needs_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken |-> $past(valid_in) && ($past(branch_op) != br_none))
    else $error("branch_taken without a branch issued");

  // Reset acts asynchronously, checked mid cycle
  a_reset_quiet: assert property (@(negedge clk)
    !rst_n |-> !valid_out && !control_any && alu_data == '0 && memory_data == '0
               && branch_target == '0 && rd_out == '0)
    else $error("outputs not cleared during reset");

endmodule

bind execute_stage execute_stage_props #(.DATA_WIDTH(DATA_WIDTH)) u_props (
  .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .branch_op(branch_op),
  .valid_out(valid_out), .reg_write_out(reg_write_out), .mem_read_out(mem_read_out),
  .mem_write_out(mem_write_out), .branch_taken(branch_taken), .alu_data(alu_data),
  .memory_data(memory_data), .branch_target(branch_target), .rd_out(rd_out)
);

`default_nettype wire

/* testbench/execute_stage_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage_tb;

  import riscv_pkg::*;

  localparam int DATA_WIDTH = XLEN_DEFAULT;
  localparam int SHAMT_W = $clog2(DATA_WIDTH);
  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 3;
  localparam int ALU_ISSUES = 11 * 2 * 4;  // Opcodes x operand source x repeats
  localparam int BRANCH_ISSUES = 8 * 6;
  localparam int RANDOM_ISSUES = 160;
  localparam int MAX_GAP = 2;
  localparam int SETTLE_CYCLES = 8;  // Gaps between phases and final drain
  localparam int TOTAL_CYCLES = RESET_CYCLES + ALU_ISSUES + BRANCH_ISSUES
                              + RANDOM_ISSUES * (1 + MAX_GAP) + SETTLE_CYCLES;
  localparam int TIMEOUT_NS = CLK_PERIOD * TOTAL_CYCLES + 1000;
  localparam logic [DATA_WIDTH-1:0] SIGN_BIT = {1'b1, {(DATA_WIDTH-1){1'b0}}};

  // Everything presented to the stage in one issue cycle
  typedef struct packed {
    logic [DATA_WIDTH-1:0] pc, data1, data2, immediate, ex_mem_result, mem_wb_result;
    logic [REG_ADDR_W-1:0] rs1, rs2, rd_in, ex_mem_rd, mem_wb_rd;
    alu_op_t               alu_op;
    branch_op_t            branch_op;
    logic alu_src, mem_read, mem_write, reg_write, ex_mem_reg_write, mem_wb_reg_write;
  } issue_t;

  // One EX/MEM record as it should leave the stage
  typedef struct packed {
    logic [DATA_WIDTH-1:0] alu_data, memory_data, branch_target;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_write, mem_read, mem_write, taken;
  } expect_t;

  logic clk = 1'b0;
  logic rst_n, valid_in;
  logic [DATA_WIDTH-1:0] pc, data1, data2, immediate, ex_mem_result, mem_wb_result;
  logic [REG_ADDR_W-1:0] rs1, rs2, rd_in, ex_mem_rd, mem_wb_rd;
  alu_op_t    alu_op;
  branch_op_t branch_op;
  logic alu_src, mem_read, mem_write, reg_write, ex_mem_reg_write, mem_wb_reg_write;
  logic valid_out, reg_write_out, mem_read_out, mem_write_out, branch_taken;
  logic [DATA_WIDTH-1:0] alu_data, memory_data, branch_target;
  logic [REG_ADDR_W-1:0] rd_out;

  int      seed = 32'h781c586f;
  expect_t expected_q[$];
  logic    valid_seen = 1'b0;  // valid_in as seen one cycle earlier

  execute_stage #(.DATA_WIDTH(DATA_WIDTH)) uut (.*);

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    end_with_failure();
  endtask

  task automatic check_field(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] want);
    assert (got === want) else begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, want);
      end_with_failure();
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  // Small values and small negatives make equal and signed cases common
  function automatic logic [DATA_WIDTH-1:0] pick_data();
    case (rand_below(4))
      0:       return DATA_WIDTH'(rand_below(8));
      1:       return '1 - DATA_WIDTH'(rand_below(8));
      default: return DATA_WIDTH'({$random(seed)});
    endcase
  endfunction

  // Youngest writer first and x0 always reads the register file
  function automatic logic [DATA_WIDTH-1:0] operand_of(input logic [REG_ADDR_W-1:0] src,
                                                       input logic [DATA_WIDTH-1:0] rf,
                                                       input issue_t t);
    if (src == '0)
      return rf;
    if (t.ex_mem_reg_write && t.ex_mem_rd == src)
      return t.ex_mem_result;
    if (t.mem_wb_reg_write && t.mem_wb_rd == src)
      return t.mem_wb_result;
    return rf;
  endfunction

  function automatic expect_t predict(input issue_t t);
    logic [DATA_WIDTH-1:0] a, b_reg, b, alu_value;
    logic [SHAMT_W-1:0]    sh;
    logic                  lt_s, lt_u, cond;
    expect_t               e;
    a = operand_of(t.rs1, t.data1, t);
    b_reg = operand_of(t.rs2, t.data2, t);
    b = t.alu_src ? t.immediate : b_reg;
    sh = b[SHAMT_W-1:0];
    lt_s = (a ^ SIGN_BIT) < (b ^ SIGN_BIT);  // Signed compare by flipping the sign bit
    lt_u = a < b;
    case (t.alu_op)
      alu_add:    alu_value = a + b;
      alu_sub:    alu_value = a + ~b + DATA_WIDTH'(1);
      alu_and:    alu_value = a & b;
      alu_or:     alu_value = a | b;
      alu_xor:    alu_value = a ^ b;
      alu_sll:    alu_value = a << sh;
      alu_srl:    alu_value = a >> sh;
      alu_sra:    alu_value = (a >> sh) | (a[DATA_WIDTH-1] ? ~('1 >> sh) : '0);
      alu_slt:    alu_value = DATA_WIDTH'(lt_s);
      alu_sltu:   alu_value = DATA_WIDTH'(lt_u);
      alu_pass_b: alu_value = b;
      default:    alu_value = '0;
    endcase
    case (t.branch_op)
      br_beq:  cond = a == b_reg;
      br_bne:  cond = a != b_reg;
      br_blt:  cond = (a ^ SIGN_BIT) < (b_reg ^ SIGN_BIT);
      br_bge:  cond = (a ^ SIGN_BIT) >= (b_reg ^ SIGN_BIT);
      br_bltu: cond = a < b_reg;
      br_bgeu: cond = a >= b_reg;
      br_jal:  cond = 1'b1;
      default: cond = 1'b0;
    endcase
    e.alu_data = (t.branch_op == br_jal) ? t.pc + DATA_WIDTH'(4) : alu_value;
    e.memory_data = b_reg;
    e.branch_target = t.pc + t.immediate;
    e.rd = t.rd_in;
    e.reg_write = t.reg_write;
    e.mem_read = t.mem_read;
    e.mem_write = t.mem_write;
    e.taken = cond;
    return e;
  endfunction

  task automatic make_random_issue(output issue_t t);
    t.pc = DATA_WIDTH'({$random(seed)}) & ~DATA_WIDTH'(3);  // Word aligned
    t.data1 = pick_data();
    t.data2 = pick_data();
    t.immediate = pick_data();
    t.ex_mem_result = pick_data();
    t.mem_wb_result = pick_data();
    t.rs1 = REG_ADDR_W'(rand_below(4));  // x0..x3 so forwarding hits often
    t.rs2 = REG_ADDR_W'(rand_below(4));
    t.ex_mem_rd = REG_ADDR_W'(rand_below(4));
    t.mem_wb_rd = REG_ADDR_W'(rand_below(4));
    t.rd_in = REG_ADDR_W'(rand_below(32));
    t.alu_op = alu_op_t'(4'(rand_below(11)));
    t.branch_op = branch_op_t'(3'(rand_below(8)));
    t.alu_src = 1'(rand_below(2));
    t.mem_read = 1'(rand_below(2));
    t.mem_write = 1'(rand_below(2));
    t.reg_write = 1'(rand_below(2));
    t.ex_mem_reg_write = 1'(rand_below(2));
    t.mem_wb_reg_write = 1'(rand_below(2));
  endtask

  task automatic apply_inputs(input issue_t t, input logic valid);
    valid_in <= valid;
    pc <= t.pc;
    data1 <= t.data1;
    data2 <= t.data2;
    immediate <= t.immediate;
    rs1 <= t.rs1;
    rs2 <= t.rs2;
    rd_in <= t.rd_in;
    alu_op <= t.alu_op;
    alu_src <= t.alu_src;
    branch_op <= t.branch_op;
    mem_read <= t.mem_read;
    mem_write <= t.mem_write;
    reg_write <= t.reg_write;
    ex_mem_rd <= t.ex_mem_rd;
    ex_mem_reg_write <= t.ex_mem_reg_write;
    ex_mem_result <= t.ex_mem_result;
    mem_wb_rd <= t.mem_wb_rd;
    mem_wb_reg_write <= t.mem_wb_reg_write;
    mem_wb_result <= t.mem_wb_result;
  endtask

  task automatic issue_instruction(input issue_t t);
    apply_inputs(t, 1'b1);
    expected_q.push_back(predict(t));
    @(posedge clk);
  endtask

  // Bubble with junk on every other input
  task automatic idle_cycle();
    issue_t junk;
    make_random_issue(junk);
    apply_inputs(junk, 1'b0);
    @(posedge clk);
  endtask

  initial begin : stimulus
    issue_t t;
    rst_n = 1'b0;
    apply_inputs('0, 1'b0);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    for (int op = 0; op < 11; op++) begin
      for (int src = 0; src < 2; src++) begin
        for (int k = 0; k < 4; k++) begin
          make_random_issue(t);
          t.alu_op = alu_op_t'(4'(op));
          t.alu_src = 1'(src);
          t.branch_op = br_none;
          if (k == 0) begin
            t.immediate[SHAMT_W-1:0] = '1;  // Largest shift amount
            t.data2[SHAMT_W-1:0] = '1;
          end
          issue_instruction(t);
        end
      end
    end
    repeat (2) idle_cycle();
    for (int br = 0; br < 8; br++) begin
      for (int k = 0; k < 6; k++) begin
        make_random_issue(t);
        t.branch_op = branch_op_t'(3'(br));
        if (k % 2 == 1)
          t.data2 = t.data1;
        if (k == 3)
          t.rs2 = t.rs1;  // Equal through forwarding as well
        issue_instruction(t);
      end
    end
    repeat (2) idle_cycle();
    repeat (RANDOM_ISSUES) begin
      make_random_issue(t);
      issue_instruction(t);
      repeat (rand_below(MAX_GAP + 1)) idle_cycle();
    end
    repeat (3) idle_cycle();
    if (expected_q.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      report_failure($sformatf("%0d issued instructions never left the stage",
                               expected_q.size()));
    end
  end

  // Outputs settle between edges
  always @(negedge clk) begin : compare_outputs
    expect_t want;
    check_field("valid_out", DATA_WIDTH'(valid_out), DATA_WIDTH'(valid_seen));
    valid_seen = valid_in;
    if (valid_out) begin
      if (expected_q.size() == 0) begin
        report_failure("valid_out went high with no instruction in flight");
      end else begin
        want = expected_q.pop_front();
        check_field("alu_data", alu_data, want.alu_data);
        check_field("memory_data", memory_data, want.memory_data);
        check_field("branch_target", branch_target, want.branch_target);
        check_field("rd_out", DATA_WIDTH'(rd_out), DATA_WIDTH'(want.rd));
        check_field("reg_write_out", DATA_WIDTH'(reg_write_out), DATA_WIDTH'(want.reg_write));
        check_field("mem_read_out", DATA_WIDTH'(mem_read_out), DATA_WIDTH'(want.mem_read));
        check_field("mem_write_out", DATA_WIDTH'(mem_write_out), DATA_WIDTH'(want.mem_write));
        check_field("branch_taken", DATA_WIDTH'(branch_taken), DATA_WIDTH'(want.taken));
      end
    end else begin
      check_field("reg_write_out", DATA_WIDTH'(reg_write_out), '0);  // Bubble or reset
      check_field("mem_read_out", DATA_WIDTH'(mem_read_out), '0);
      check_field("mem_write_out", DATA_WIDTH'(mem_write_out), '0);
      check_field("branch_taken", DATA_WIDTH'(branch_taken), '0);
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    report_failure($sformatf("Run timed out after %0d ns", TIMEOUT_NS));
  end

endmodule

`default_nettype wire

/* sources.f */
common/riscv_pkg.sv
execute/forwarding_unit.sv
execute/alu.sv
execute/branch_unit.sv
execute/ex_mem_register.sv
execute/execute_stage.sv
testbench/execute_stage_props.sv
testbench/execute_stage_tb.sv

/* Makefile */
TOP := execute_stage_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "Test passed" sim.log || { echo "Simulation ended without passing"; exit 1; }

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
